/* logic/vec_types_pkg.sv */
// ==========================================================================
// Vector element types
// Width encoding, element and register types, register file geometry
// ==========================================================================

package vec_types_pkg;

  // ========================================================================
  // Element width encoding
  // ========================================================================

  typedef logic [1:0] sew_t;

  localparam sew_t SEW8     = 2'd0;
  localparam sew_t SEW16    = 2'd1;
  localparam sew_t SEW32    = 2'd2;
  // No element width maps to this one
  localparam sew_t SEW_RSVD = 2'd3;

  // ========================================================================
  // Register file geometry
  // ========================================================================

  localparam int NUM_REGS = 32;
  // 128-bit registers
  localparam int VLENB    = 16;

  // One register, byte addressable, byte 0 in the low bits
  typedef logic [VLENB-1:0][7:0] vreg_t;

  // Register number, wraps modulo NUM_REGS
  typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;

  // Byte position inside a register
  typedef logic [$clog2(VLENB)-1:0] byte_idx_t;

  // Element value as seen on the ports, zero-extended
  typedef logic [31:0] elem_t;

  // Read value for a reserved width
  localparam elem_t BAD_ELEM = 32'hDED0_DED0;

endpackage

/* logic/vrf_cfg_pkg.sv */
// ==========================================================================
// Vector register file configuration
// Lane count, element offset and vector length sizes
// ==========================================================================

package vrf_cfg_pkg;

  // Elements handled per cycle on each operand
  localparam int LANES    = 2;

  // Offset reaches 128 byte elements across an 8-register group
  localparam int OFFSET_W = 7;

  typedef logic [OFFSET_W-1:0] offset_t;

  // One bit wider so vl can hold 128
  typedef logic [OFFSET_W:0] vl_t;

endpackage

/* logic/vrf_elem_if.sv */
// ==========================================================================
// Located element bundle
// Register index, byte position, width and raw offset of one element
// ==========================================================================

`timescale 1ns/10ps

interface vrf_elem_if
  import vec_types_pkg::*, vrf_cfg_pkg::*;
();

  // Register inside the group, already wrapped
  reg_idx_t  reg_idx;
  // First byte of the element in that register
  byte_idx_t byte_off;
  sew_t      sew;
  // Raw element offset, also the bit number in mask mode
  offset_t   elem_idx;

  modport locator (
    output reg_idx,
    output byte_off,
    output sew,
    output elem_idx
  );

  modport user (
    input  reg_idx,
    input  byte_off,
    input  sew,
    input  elem_idx
  );

endinterface

/* logic/elem_locator.sv */
// ==========================================================================
// Element locator
// Base register, width and element offset to register and byte position
// ==========================================================================

`timescale 1ns/10ps

module elem_locator
  import vec_types_pkg::*, vrf_cfg_pkg::*;
(
  input  reg_idx_t    base,
  input  sew_t        sew,
  input  offset_t     offset,
  vrf_elem_if.locator loc
);

  // Registers past the base, and byte start inside the register
  reg_idx_t  grp_step;
  byte_idx_t byte_pos;

  // Four, eight or sixteen elements fit in one register
  always_comb begin
    case (sew)
      SEW32: begin
        grp_step = offset[6:2];
        byte_pos = {offset[1:0], 2'b00};
      end
      SEW16: begin
        grp_step = {1'b0, offset[6:3]};
        byte_pos = {offset[2:0], 1'b0};
      end
      default: begin
        // SEW8, also the reserved code
        grp_step = {2'b00, offset[6:4]};
        byte_pos = offset[3:0];
      end
    endcase
  end

  // 5-bit sum, so the group wraps past v31 back to v0
  assign loc.reg_idx  = base + grp_step;
  assign loc.byte_off = byte_pos;

  // Width and raw offset go on for extraction and bit writes
  assign loc.sew      = sew;
  assign loc.elem_idx = offset;

endmodule

/* logic/vreg_storage.sv */
// ==========================================================================
// Vector register storage
// 32 x 128-bit registers, per-lane element or bit writes gated by vl
// ==========================================================================

`timescale 1ns/10ps

module vreg_storage
  import vec_types_pkg::*, vrf_cfg_pkg::*;
(
  input  logic                CLK,
  input  logic                nRST,
  vrf_elem_if.user            rd_loc [2*LANES],
  vrf_elem_if.user            wr_loc [LANES],
  input  logic    [LANES-1:0] wen,
  input  elem_t   [LANES-1:0] w_data,
  input  vl_t                 vl,
  input  logic                single_bit_write,
  output vreg_t [2*LANES-1:0] rd_word,
  output vreg_t               v0_word
);

  vreg_t [NUM_REGS-1:0] regs;
  vreg_t [NUM_REGS-1:0] next_regs;

  // Write locations flattened per lane
  reg_idx_t  [LANES-1:0] wr_reg;
  byte_idx_t [LANES-1:0] wr_byte;
  sew_t      [LANES-1:0] wr_sew;
  offset_t   [LANES-1:0] wr_elem;
  // Base register recovered for mask mode
  reg_idx_t  [LANES-1:0] bit_reg;
  logic      [LANES-1:0] wr_ok;

  for (genvar g = 0; g < LANES; g++) begin : g_wr
    assign wr_reg[g]  = wr_loc[g].reg_idx;
    assign wr_byte[g] = wr_loc[g].byte_off;
    assign wr_sew[g]  = wr_loc[g].sew;
    assign wr_elem[g] = wr_loc[g].elem_idx;
  end

  // ========================================================================
  // Read side
  // ========================================================================

  for (genvar g = 0; g < 2*LANES; g++) begin : g_rd
    assign rd_word[g] = regs[rd_loc[g].reg_idx];
  end

  assign v0_word = regs[0];

  // ========================================================================
  // Write side
  // ========================================================================

  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      // Undo the group step so mask mode addresses vd itself
      case (wr_sew[l])
        SEW32:   bit_reg[l] = wr_reg[l] - wr_elem[l][6:2];
        SEW16:   bit_reg[l] = wr_reg[l] - {1'b0, wr_elem[l][6:3]};
        default: bit_reg[l] = wr_reg[l] - {2'b00, wr_elem[l][6:4]};
      endcase
      wr_ok[l] = wen[l] && (vl_t'(wr_elem[l]) < vl) &&
                 (single_bit_write || (wr_sew[l] != SEW_RSVD));
    end
  end

  // Lanes applied in order, the higher lane wins on overlap
  always_comb begin
    next_regs = regs;
    for (int l = 0; l < LANES; l++) begin
      if (wr_ok[l]) begin
        if (single_bit_write) begin
          next_regs[bit_reg[l]][wr_elem[l][6:3]][wr_elem[l][2:0]] = w_data[l][0];
        end else begin
          case (wr_sew[l])
            SEW32:   next_regs[wr_reg[l]][wr_byte[l] +: 4] = w_data[l];
            SEW16:   next_regs[wr_reg[l]][wr_byte[l] +: 2] = w_data[l][15:0];
            default: next_regs[wr_reg[l]][wr_byte[l]]      = w_data[l][7:0];
          endcase
        end
      end
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      regs <= '0;
    end else begin
      regs <= next_regs;
    end
  end

endmodule

/* logic/elem_extract.sv */
// ==========================================================================
// Element extractor
// Picks and zero-extends one element of a register and its v0 mask bit
// ==========================================================================

`timescale 1ns/10ps

module elem_extract
  import vec_types_pkg::*;
(
  vrf_elem_if.user loc,
  input  vreg_t    word,
  input  vreg_t    v0,
  output elem_t    data,
  output logic     mask
);

  // Element bytes at their located position
  logic [3:0][7:0] bytes4;
  logic [1:0][7:0] bytes2;
  logic [7:0]      byte1;

  assign bytes4 = word[loc.byte_off +: 4];
  assign bytes2 = word[loc.byte_off +: 2];
  assign byte1  = word[loc.byte_off];

  // Zero-extend to the 32-bit port
  always_comb begin
    case (loc.sew)
      SEW32:   data = bytes4;
      SEW16:   data = {16'h0000, bytes2};
      SEW8:    data = {24'h00_0000, byte1};
      default: data = BAD_ELEM;
    endcase
  end

  // One mask bit per element, element n at bit n of v0
  assign mask = v0[loc.elem_idx[6:3]][loc.elem_idx[2:0]];

endmodule

/* logic/vec_reg_file.sv */
// ==========================================================================
// Vector register file
// Element addressed reads of vs1 and vs2, per-lane writes of vd
// ==========================================================================

`timescale 1ns/10ps

module vec_reg_file
  import vec_types_pkg::*, vrf_cfg_pkg::*;
(
  input  logic                CLK,
  input  logic                nRST,
  // Read operands
  input  reg_idx_t            vs1,
  input  reg_idx_t            vs2,
  input  sew_t                sew,
  input  sew_t                vs2_sew,
  input  offset_t [LANES-1:0] vs1_offset,
  input  offset_t [LANES-1:0] vs2_offset,
  output elem_t   [LANES-1:0] vs1_data,
  output elem_t   [LANES-1:0] vs2_data,
  output logic    [LANES-1:0] vs1_mask,
  output logic    [LANES-1:0] vs2_mask,
  // Destination
  input  reg_idx_t            vd,
  input  sew_t                eew,
  input  offset_t [LANES-1:0] vd_offset,
  input  logic    [LANES-1:0] wen,
  input  elem_t   [LANES-1:0] w_data,
  input  vl_t                 vl,
  input  logic                single_bit_write
);

  // vs1 lanes first, then vs2 lanes
  vrf_elem_if rd_if [2*LANES] ();
  vrf_elem_if wr_if [LANES] ();

  vreg_t [2*LANES-1:0] rd_word;
  vreg_t               v0_word;

  for (genvar l = 0; l < LANES; l++) begin : g_lane
    elem_locator u_vs1_loc (
      .base   (vs1),
      .sew    (sew),
      .offset (vs1_offset[l]),
      .loc    (rd_if[l])
    );

    elem_locator u_vs2_loc (
      .base   (vs2),
      .sew    (vs2_sew),
      .offset (vs2_offset[l]),
      .loc    (rd_if[LANES+l])
    );

    elem_locator u_vd_loc (
      .base   (vd),
      .sew    (eew),
      .offset (vd_offset[l]),
      .loc    (wr_if[l])
    );

    elem_extract u_vs1_ext (
      .loc  (rd_if[l]),
      .word (rd_word[l]),
      .v0   (v0_word),
      .data (vs1_data[l]),
      .mask (vs1_mask[l])
    );

    elem_extract u_vs2_ext (
      .loc  (rd_if[LANES+l]),
      .word (rd_word[LANES+l]),
      .v0   (v0_word),
      .data (vs2_data[l]),
      .mask (vs2_mask[l])
    );
  end

  vreg_storage u_storage (
    .CLK              (CLK),
    .nRST             (nRST),
    .rd_loc           (rd_if),
    .wr_loc           (wr_if),
    .wen              (wen),
    .w_data           (w_data),
    .vl               (vl),
    .single_bit_write (single_bit_write),
    .rd_word          (rd_word),
    .v0_word          (v0_word)
  );

endmodule

/* bench/vec_reg_file_props.sv */
// ==========================================================================
// Vector register file properties
// Read data known, reserved width reads, mask outputs known
// ==========================================================================

`timescale 1ns/10ps

module vec_reg_file_props
  import vec_types_pkg::*, vrf_cfg_pkg::*;
(
  input logic              CLK,
  input logic              nRST,
  input sew_t              sew,
  input sew_t              vs2_sew,
  input elem_t [LANES-1:0] vs1_data,
  input elem_t [LANES-1:0] vs2_data,
  input logic  [LANES-1:0] vs1_mask,
  input logic  [LANES-1:0] vs2_mask
);

  a_data_known: assert property (@(posedge CLK) disable iff (!nRST)
    !$isunknown({vs1_data, vs2_data}))
    else $error("read data has unknown bits");

  // Width code 3 is reserved
  a_vs1_rsvd: assert property (@(posedge CLK) disable iff (!nRST)
    (sew == 2'd3) |-> (vs1_data == {LANES{32'hDED0_DED0}}))
    else $error("vs1 read with reserved width did not return DED0DED0");

  a_vs2_rsvd: assert property (@(posedge CLK) disable iff (!nRST)
    (vs2_sew == 2'd3) |-> (vs2_data == {LANES{32'hDED0_DED0}}))
    else $error("vs2 read with reserved width did not return DED0DED0");

  a_mask_known: assert property (@(posedge CLK)
    (nRST && $past(nRST)) |-> !$isunknown({vs1_mask, vs2_mask}))
    else $error("mask output has unknown bits");

endmodule

bind vec_reg_file vec_reg_file_props u_props (.*);

/* bench/vec_reg_file_tb.sv */
// ==========================================================================
// Vector register file testbench
// Random element and bit traffic checked against a register model
// ==========================================================================

`timescale 1ns/10ps

module vec_reg_file_tb
  import vec_types_pkg::*, vrf_cfg_pkg::*;
();

  localparam int RESET_CYCLES = 8;
  localparam int N_RESET_RD   = 20;
  localparam int N_ELEM_WR    = 60;
  localparam int N_GATED      = 40;
  localparam int N_BIT_WR     = 40;
  localparam int N_CONFLICT   = 20;
  localparam int TOTAL_CYCLES = RESET_CYCLES + N_RESET_RD + N_ELEM_WR + N_GATED +
                                N_BIT_WR + N_CONFLICT;

  logic                CLK;
  logic                nRST;
  reg_idx_t            vs1, vs2, vd;
  sew_t                sew, vs2_sew, eew;
  offset_t [LANES-1:0] vs1_offset, vs2_offset, vd_offset;
  elem_t   [LANES-1:0] vs1_data, vs2_data, w_data;
  logic    [LANES-1:0] vs1_mask, vs2_mask, wen;
  vl_t                 vl;
  logic                single_bit_write;

  // Reference copy of the 32 registers
  logic [127:0] model_regs [NUM_REGS];
  logic [31:0]  rng_state = 32'h16b5_a49e;
  int           test_errs = 0;
  int           tests_passed = 0;
  int           tests_failed = 0;

  vec_reg_file UUT (.*);

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // ========================================================================
  // Random numbers and reference model
  // ========================================================================

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Element n of a group sits at register base + n / per_reg
  function automatic elem_t model_read(reg_idx_t base, sew_t w, offset_t off);
    int           size;
    int           per_reg;
    reg_idx_t     r;
    logic [127:0] word;
    if (w == 2'd3) begin
      return 32'hDED0_DED0;
    end
    size    = 1 << w;
    per_reg = VLENB / size;
    r       = reg_idx_t'(base + off / per_reg);
    word    = model_regs[r] >> ((off % per_reg) * size * 8);
    return word[31:0] & elem_t'((64'd1 << (size * 8)) - 1);
  endfunction

  // Lanes in order, so lane 1 overwrites lane 0
  task automatic model_write();
    int       size;
    int       per_reg;
    int       pos;
    reg_idx_t r;
    for (int l = 0; l < LANES; l++) begin
      if (wen[l] && vd_offset[l] < vl) begin
        if (single_bit_write) begin
          model_regs[vd][vd_offset[l]] = w_data[l][0];
        end else if (eew != 2'd3) begin
          size    = 1 << eew;
          per_reg = VLENB / size;
          r       = reg_idx_t'(vd + vd_offset[l] / per_reg);
          pos     = (vd_offset[l] % per_reg) * size;
          for (int b = 0; b < size; b++) begin
            model_regs[r][(pos + b) * 8 +: 8] = w_data[l][b * 8 +: 8];
          end
        end
      end
    end
  endtask

  // ========================================================================
  // Checks and stimulus
  // ========================================================================

  task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %h actual %h at %0t", name, exp, act, $time);
      test_errs++;
    end
  endtask

  task automatic check_reads();
    for (int l = 0; l < LANES; l++) begin
      check_value($sformatf("vs1_data[%0d]", l), model_read(vs1, sew, vs1_offset[l]),
                  vs1_data[l]);
      check_value($sformatf("vs2_data[%0d]", l), model_read(vs2, vs2_sew, vs2_offset[l]),
                  vs2_data[l]);
      check_value($sformatf("vs1_mask[%0d]", l), model_regs[0][vs1_offset[l]], vs1_mask[l]);
      check_value($sformatf("vs2_mask[%0d]", l), model_regs[0][vs2_offset[l]], vs2_mask[l]);
    end
  endtask

  // Check just before the edge, then let the write land
  task automatic finish_cycle();
    #36;
    check_reads();
    model_write();
    @(posedge CLK);
    #2;
  endtask

  task automatic random_reads();
    logic [31:0] r;
    r       = next_random();
    vs1     = r[4:0];
    vs2     = r[9:5];
    sew     = sew_t'(r[13:10] % 3);
    vs2_sew = sew_t'(r[17:14] % 3);
    for (int l = 0; l < LANES; l++) begin
      r             = next_random();
      vs1_offset[l] = r[6:0];
      vs2_offset[l] = r[13:7];
    end
  endtask

  // Point both read operands at the last write
  task automatic follow_write();
    vs1        = vd;
    vs2        = vd;
    vs1_offset = vd_offset;
    if (eew != 2'd3) begin
      sew = eew;
    end
  endtask

  task automatic random_write();
    logic [31:0] r;
    r   = next_random();
    vd  = r[4:0];
    eew = sew_t'(r[8:5] % 3);
    wen = r[10:9];
    // Top of the file, so groups wrap past v31
    if (r[11]) begin
      vd[4:2] = 3'b111;
    end
    for (int l = 0; l < LANES; l++) begin
      r            = next_random();
      vd_offset[l] = r[6:0];
      w_data[l]    = next_random();
    end
  endtask

  task automatic end_test(string name);
    if (test_errs == 0) begin
      $display("Test %s: passed", name);
      tests_passed++;
    end else begin
      $display("Test %s: FAILED with %0d errors", name, test_errs);
      tests_failed++;
    end
    test_errs = 0;
  endtask

  // ========================================================================
  // Test sequence
  // ========================================================================

  initial begin
    logic [31:0] r;
    nRST             = 1'b0;
    vs1              = '0;
    vs2              = '0;
    sew              = '0;
    vs2_sew          = '0;
    vs1_offset       = '0;
    vs2_offset       = '0;
    vd               = '0;
    eew              = '0;
    vd_offset        = '0;
    wen              = '0;
    w_data           = '0;
    vl               = '0;
    single_bit_write = 1'b0;
    foreach (model_regs[i]) begin
      model_regs[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge CLK);
    #2;
    nRST = 1'b1;

    for (int i = 0; i < N_RESET_RD; i++) begin
      random_reads();
      finish_cycle();
    end
    end_test("reads after reset");

    vl = 8'd128;
    for (int i = 0; i < N_ELEM_WR; i++) begin
      random_reads();
      follow_write();
      random_write();
      finish_cycle();
    end
    end_test("element writes");

    for (int i = 0; i < N_GATED; i++) begin
      random_reads();
      follow_write();
      random_write();
      r  = next_random();
      vl = vl_t'(r[7:0] % 129);
      case (r[9:8])
        2'd0: wen = '0;
        2'd1: eew = 2'd3;
        default: begin
          // No offset lies at or above a full vl
          if (vl == 8'd128) begin
            wen = '0;
          end else begin
            for (int l = 0; l < LANES; l++) begin
              vd_offset[l] = offset_t'(vl + next_random() % (32'd128 - vl));
            end
          end
        end
      endcase
      finish_cycle();
    end
    end_test("gated writes");

    vl               = 8'd128;
    single_bit_write = 1'b1;
    for (int i = 0; i < N_BIT_WR; i++) begin
      random_reads();
      follow_write();
      vs2_offset = vd_offset;
      random_write();
      r = next_random();
      // Mostly v0, so the mask outputs see the bits
      if (r[1:0] != 2'd0) begin
        vd = '0;
      end
      finish_cycle();
    end
    end_test("single-bit writes");

    single_bit_write = 1'b0;
    for (int i = 0; i < N_CONFLICT; i++) begin
      random_reads();
      follow_write();
      random_write();
      wen          = '1;
      vd_offset[1] = vd_offset[0];
      r            = next_random();
      if (r[0]) begin
        sew = 2'd3;
      end
      if (r[1]) begin
        vs2_sew = 2'd3;
      end
      finish_cycle();
    end
    end_test("lane conflict and reserved reads");

    $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #((TOTAL_CYCLES + 20) * 40);
    $display("Timeout: the tests did not finish in the expected time");
    $display("Simulation failed");
    $finish;
  end

endmodule

/* tb.f */
logic/vec_types_pkg.sv
logic/vrf_cfg_pkg.sv
logic/vrf_elem_if.sv
logic/elem_locator.sv
logic/vreg_storage.sv
logic/elem_extract.sv
logic/vec_reg_file.sv
bench/vec_reg_file_props.sv
bench/vec_reg_file_tb.sv
